// File: mvm_params.svh
`ifndef MVM_PARAMS_SVH
`define MVM_PARAMS_SVH

// ********************************************************************
// layer geometry and word width
// ********************************************************************

// signed fixed point word
`define MVM_DATA_W 16

// input vector length and weight columns
`define MVM_N_IN 8

// lanes, one per output
`define MVM_N_OUT 16

// address widths
`define MVM_IN_AW 3
`define MVM_OUT_AW 4

`endif

// File: mvm_pkg.sv
`default_nettype none

`include "mvm_params.svh"

package mvm_pkg;

   typedef logic signed [`MVM_DATA_W-1:0] data_t;   // every datapath value

   typedef enum logic [1:0] {
      st_load,      // taking input words
      st_compute,   // issuing column addresses
      st_drain,     // pipeline flush
      st_output     // results out, lane order
   } ctrl_state_t;

endpackage

`default_nettype wire

// File: layer_rom.sv
`timescale 1ns/1ns
`default_nettype none

`include "mvm_params.svh"

module layer_rom import mvm_pkg::*; (
   input  logic                  clk,
   input  logic [`MVM_IN_AW-1:0] rd_addr,
   output data_t                 weight [`MVM_N_OUT],
   output data_t                 bias [`MVM_N_OUT]
);

   // ********************************************************************
   // weight table, one row per lane, one column per input
   // ********************************************************************
   localparam data_t W_TABLE [`MVM_N_OUT][`MVM_N_IN] = '{
      '{-16'sd110,  16'sd20,  -16'sd88,  -16'sd10,   16'sd90,  -16'sd82,   16'sd92,  -16'sd94},
      '{ 16'sd100, -16'sd114, -16'sd37,   16'sd3,   -16'sd55,  -16'sd42,  -16'sd65,  -16'sd23},
      '{ 16'sd55,  -16'sd112,  16'sd49,   16'sd112, -16'sd94,  -16'sd74,  -16'sd117,  16'sd41},
      '{ 16'sd118, -16'sd58,  -16'sd111, -16'sd7,    16'sd107,  16'sd103,  16'sd54,   16'sd126},
      '{-16'sd5,    16'sd94,  -16'sd12,  -16'sd42,  -16'sd116, -16'sd48,  -16'sd8,    16'sd113},
      '{-16'sd33,   16'sd84,  -16'sd12,   16'sd40,  -16'sd86,   16'sd52,  -16'sd111,  16'sd97},
      '{ 16'sd68,   16'sd66,   16'sd81,   16'sd102,  16'sd120,  16'sd92,   16'sd15,   16'sd111},
      '{-16'sd94,   16'sd32,  -16'sd24,  -16'sd114,  16'sd7,   -16'sd98,  -16'sd116, -16'sd125},
      '{ 16'sd124,  16'sd0,   -16'sd39,  -16'sd119,  16'sd81,   16'sd81,   16'sd122, -16'sd80},
      '{ 16'sd37,  -16'sd18,   16'sd88,   16'sd80,  -16'sd94,   16'sd106,  16'sd49,   16'sd102},
      '{ 16'sd44,   16'sd3,    16'sd76,   16'sd37,  -16'sd33,  -16'sd37,   16'sd20,   16'sd2},
      '{ 16'sd124,  16'sd124,  16'sd16,   16'sd3,   -16'sd101,  16'sd28,   16'sd6,   -16'sd105},
      '{-16'sd100,  16'sd95,  -16'sd96,   16'sd109,  16'sd49,  -16'sd102, -16'sd99,  -16'sd42},
      '{ 16'sd9,    16'sd118, -16'sd90,   16'sd43,   16'sd96,   16'sd88,   16'sd18,   16'sd12},
      '{-16'sd37,  -16'sd34,  -16'sd79,   16'sd58,   16'sd58,   16'sd69,  -16'sd68,   16'sd54},
      '{ 16'sd66,   16'sd76,  -16'sd71,   16'sd93,  -16'sd24,   16'sd64,   16'sd116,  16'sd5}
   };

   // bias per lane
   localparam data_t B_TABLE [`MVM_N_OUT] = '{
       16'sd31,  -16'sd107, -16'sd14,  -16'sd48,
      -16'sd81,   16'sd16,   16'sd39,   16'sd56,
       16'sd6,    16'sd77,  -16'sd28,  -16'sd26,
       16'sd37,   16'sd118,  16'sd114, -16'sd128
   };

   // ********************************************************************
   // column read, one cycle latency like the input buffer
   // ********************************************************************
   always_ff @(posedge clk) begin
      for (int j = 0; j < `MVM_N_OUT; j++) begin
         weight[j] <= W_TABLE[j][rd_addr];
      end
   end

   always_comb begin
      for (int j = 0; j < `MVM_N_OUT; j++) begin
         bias[j] = B_TABLE[j];   // constant, no address
      end
   end

endmodule

`default_nettype wire

// File: input_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "mvm_params.svh"

module input_buffer import mvm_pkg::*; (
   input  logic                  clk,
   input  logic                  x_wr,
   input  logic [`MVM_IN_AW-1:0] x_addr,
   input  data_t                 data_in,
   input  logic [`MVM_IN_AW-1:0] rd_addr,
   output data_t                 x_data
);

   data_t mem [`MVM_N_IN];   // input vector

   always_ff @(posedge clk) begin
      if (x_wr) begin
         mem[x_addr] <= data_in;
      end
      x_data <= mem[rd_addr];   // broadcast to all lanes
   end

   a_wr_range: assert property (@(posedge clk) x_wr |-> !$isunknown(x_addr))
      else $error("input buffer write with unknown address");

endmodule

`default_nettype wire

// File: mac_lane.sv
`timescale 1ns/1ns
`default_nettype none

`include "mvm_params.svh"

module mac_lane import mvm_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  data_t weight,
   input  data_t x_data,
   input  data_t bias,
   input  logic  acc_load,
   input  logic  acc_en,
   output data_t result
);

   data_t product;   // low word of weight * x
   data_t prod_q;
   data_t acc;

   // ********************************************************************
   // multiply stage
   // ********************************************************************
   assign product = weight * x_data;   // wraps to 16 bits

   always_ff @(posedge clk) begin
      prod_q <= product;
   end

   // ********************************************************************
   // accumulate stage
   // ********************************************************************
   always_ff @(posedge clk) begin
      if (reset) begin
         acc <= '0;
      end else if (acc_load) begin
         acc <= bias;            // start of frame
      end else if (acc_en) begin
         acc <= acc + prod_q;    // wraps
      end
   end

   // relu
   assign result = acc[`MVM_DATA_W-1] ? '0 : acc;

endmodule

`default_nettype wire

// File: mvm_control.sv
`timescale 1ns/1ns
`default_nettype none

`include "mvm_params.svh"

module mvm_control import mvm_pkg::*; (
   input  logic                   clk,
   input  logic                   reset,
   input  logic                   s_valid,
   input  logic                   m_ready,
   output logic                   s_ready,
   output logic                   m_valid,
   output logic                   x_wr,
   output logic [`MVM_IN_AW-1:0]  x_addr,
   output logic [`MVM_IN_AW-1:0]  rd_addr,
   output logic                   acc_load,
   output logic                   acc_en,
   output logic [`MVM_OUT_AW-1:0] out_sel
);

   ctrl_state_t           state;
   logic [`MVM_IN_AW-1:0] in_cnt;      // accepted words
   logic [`MVM_IN_AW-1:0] rd_cnt;      // column being issued
   logic                  drain_cnt;   // two flush cycles
   logic [1:0]            en_pipe;     // rom read + product register
   logic [`MVM_IN_AW:0]   en_cnt;      // enables seen this frame
   logic                  in_last;
   logic                  out_last;
   logic                  xfer;

   assign x_wr     = s_valid && s_ready;
   assign x_addr   = in_cnt;
   assign rd_addr  = rd_cnt;
   assign xfer     = m_valid && m_ready;
   assign in_last  = x_wr && (in_cnt == `MVM_IN_AW'(`MVM_N_IN - 1));
   assign out_last = xfer && (out_sel == `MVM_OUT_AW'(`MVM_N_OUT - 1));

   // ********************************************************************
   // main FSM
   // ********************************************************************
   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= st_load;
         s_ready   <= 1'b0;
         m_valid   <= 1'b0;
         in_cnt    <= '0;
         rd_cnt    <= '0;
         drain_cnt <= 1'b0;
         out_sel   <= '0;
      end else begin
         case (state)
            st_load: begin
               s_ready <= 1'b1;
               if (x_wr) begin
                  in_cnt <= in_cnt + 1'b1;   // wraps to 0 after last word
               end
               if (in_last) begin
                  s_ready <= 1'b0;
                  rd_cnt  <= '0;
                  state   <= st_compute;
               end
            end
            st_compute: begin
               rd_cnt <= rd_cnt + 1'b1;
               if (rd_cnt == `MVM_IN_AW'(`MVM_N_IN - 1)) begin
                  drain_cnt <= 1'b0;
                  state     <= st_drain;
               end
            end
            st_drain: begin
               drain_cnt <= 1'b1;
               if (drain_cnt) begin
                  m_valid <= 1'b1;   // last product now in the accumulators
                  state   <= st_output;
               end
            end
            st_output: begin
               if (xfer) begin
                  out_sel <= out_sel + 1'b1;
               end
               if (out_last) begin
                  m_valid <= 1'b0;
                  s_ready <= 1'b1;
                  state   <= st_load;
               end
            end
            default: begin
               state <= st_load;
            end
         endcase
      end
   end

   // ********************************************************************
   // lane strobes
   // ********************************************************************
   // bias goes in while the first column is still being read
   assign acc_load = (state == st_compute) && (rd_cnt == '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         en_pipe <= '0;
      end else begin
         en_pipe <= {en_pipe[0], state == st_compute};
      end
   end

   assign acc_en = en_pipe[1];   // lines up with prod_q

   always_ff @(posedge clk) begin
      if (reset) begin
         en_cnt <= '0;
      end else if (acc_load) begin
         en_cnt <= '0;
      end else if (acc_en) begin
         en_cnt <= en_cnt + 1'b1;
      end
   end

   // ********************************************************************
   // checks
   // ********************************************************************
   a_no_overlap: assert property (@(posedge clk) disable iff (reset)
      !(s_ready && m_valid))
      else $error("s_ready and m_valid high together");

   a_sel_step: assert property (@(posedge clk) disable iff (reset)
      (out_sel != $past(out_sel)) |-> ($past(xfer) || (state == st_load)))
      else $error("out_sel moved without a transfer");

   a_en_len: assert property (@(posedge clk) disable iff (reset)
      acc_en |-> (en_cnt < `MVM_N_IN))
      else $error("acc_en longer than one vector");

endmodule

`default_nettype wire

// File: mvm_layer.sv
`timescale 1ns/1ns
`default_nettype none

`include "mvm_params.svh"

module mvm_layer import mvm_pkg::*; (
   input  logic  clk,
   input  logic  reset,
   input  logic  s_valid,
   output logic  s_ready,
   input  data_t data_in,
   output logic  m_valid,
   input  logic  m_ready,
   output data_t data_out
);

   logic                   x_wr;
   logic [`MVM_IN_AW-1:0]  x_addr;
   logic [`MVM_IN_AW-1:0]  rd_addr;
   logic                   acc_load;
   logic                   acc_en;
   logic [`MVM_OUT_AW-1:0] out_sel;
   data_t                  x_data;
   data_t                  weight [`MVM_N_OUT];
   data_t                  bias [`MVM_N_OUT];
   data_t                  lane_out [`MVM_N_OUT];

   mvm_control u_control (
      .clk      (clk),
      .reset    (reset),
      .s_valid  (s_valid),
      .m_ready  (m_ready),
      .s_ready  (s_ready),
      .m_valid  (m_valid),
      .x_wr     (x_wr),
      .x_addr   (x_addr),
      .rd_addr  (rd_addr),
      .acc_load (acc_load),
      .acc_en   (acc_en),
      .out_sel  (out_sel)
   );

   input_buffer u_input_buffer (
      .clk     (clk),
      .x_wr    (x_wr),
      .x_addr  (x_addr),
      .data_in (data_in),
      .rd_addr (rd_addr),
      .x_data  (x_data)
   );

   layer_rom u_layer_rom (
      .clk     (clk),
      .rd_addr (rd_addr),
      .weight  (weight),
      .bias    (bias)
   );

   // ********************************************************************
   // one lane per output neuron
   // ********************************************************************
   for (genvar i = 0; i < `MVM_N_OUT; i++) begin : g_lane
      mac_lane u_lane (
         .clk      (clk),
         .reset    (reset),
         .weight   (weight[i]),
         .x_data   (x_data),
         .bias     (bias[i]),
         .acc_load (acc_load),
         .acc_en   (acc_en),
         .result   (lane_out[i])
      );
   end

   assign data_out = lane_out[out_sel];   // held while m_ready low

endmodule

`default_nettype wire

// File: tb_mvm_layer.sv
`timescale 1ns/1ns
`default_nettype none

`include "mvm_params.svh"

module tb_mvm_layer import mvm_pkg::*; ();

   localparam int timeout_cycles = 3000;   // 15 frames of up to 70 cycles with 3x margin
   localparam int max_latency = 20;

   localparam int w_ref [`MVM_N_OUT][`MVM_N_IN] = '{
      '{-110,   20,  -88,  -10,   90,  -82,   92,  -94},
      '{ 100, -114,  -37,    3,  -55,  -42,  -65,  -23},
      '{  55, -112,   49,  112,  -94,  -74, -117,   41},
      '{ 118,  -58, -111,   -7,  107,  103,   54,  126},
      '{  -5,   94,  -12,  -42, -116,  -48,   -8,  113},
      '{ -33,   84,  -12,   40,  -86,   52, -111,   97},
      '{  68,   66,   81,  102,  120,   92,   15,  111},
      '{ -94,   32,  -24, -114,    7,  -98, -116, -125},
      '{ 124,    0,  -39, -119,   81,   81,  122,  -80},
      '{  37,  -18,   88,   80,  -94,  106,   49,  102},
      '{  44,    3,   76,   37,  -33,  -37,   20,    2},
      '{ 124,  124,   16,    3, -101,   28,    6, -105},
      '{-100,   95,  -96,  109,   49, -102,  -99,  -42},
      '{   9,  118,  -90,   43,   96,   88,   18,   12},
      '{ -37,  -34,  -79,   58,   58,   69,  -68,   54},
      '{  66,   76,  -71,   93,  -24,   64,  116,    5}
   };

   localparam int b_ref [`MVM_N_OUT] = '{
        31, -107,  -14,  -48,  -81,   16,   39,   56,
         6,   77,  -28,  -26,   37,  118,  114, -128
   };

   logic  clk;
   logic  reset;
   logic  s_valid;
   logic  s_ready;
   data_t data_in;
   logic  m_valid;
   logic  m_ready;
   data_t data_out;

   int          cycles = 0;
   logic [31:0] lcg_state;
   data_t       vec [`MVM_N_IN];       // vector of the current frame
   data_t       exp_out [`MVM_N_OUT];  // model results for it

   mvm_layer u_mvm_layer (
      .clk      (clk),
      .reset    (reset),
      .s_valid  (s_valid),
      .s_ready  (s_ready),
      .data_in  (data_in),
      .m_valid  (m_valid),
      .m_ready  (m_ready),
      .data_out (data_out)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // ********************************************************************
   // helpers
   // ********************************************************************
   task automatic abort_run();
      $display("Test FAILED");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check_word(input string name, input data_t expected, input data_t actual);
      assert (actual === expected) else begin
         $display("error at %0t ns: %s expected %0d, got %0d", $time, name, expected, actual);
         abort_run();
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      assert (actual === expected) else begin
         $display("error at %0t ns: %s expected %0b, got %0b", $time, name, expected, actual);
         abort_run();
      end
   endtask

   always @(posedge clk) begin
      cycles <= cycles + 1;
      if (cycles >= timeout_cycles) begin
         $display("timeout after %0d cycles, the DUT stopped responding", cycles);
         abort_run();
      end
   end

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   // bias plus products, every step wrapped to one word, then relu
   function automatic data_t model_out(input int j);
      logic signed [`MVM_DATA_W-1:0] sum;
      sum = `MVM_DATA_W'(b_ref[j]);
      for (int k = 0; k < `MVM_N_IN; k++) begin
         sum = sum + `MVM_DATA_W'(w_ref[j][k] * int'(vec[k]));
      end
      return (sum < 0) ? '0 : sum;
   endfunction

   // ********************************************************************
   // frame transfer tasks start and end 1 ns after a rising edge
   // ********************************************************************
   task automatic send_vector(input bit gaps, output int accept_cycle);
      int          n;
      logic [31:0] r;
      n = 0;
      while (n < `MVM_N_IN) begin
         r = lcg_next();
         if (gaps && r[20]) begin
            s_valid = 1'b0;
            data_in = data_t'(r[31:16]);   // junk while idle
         end else begin
            s_valid = 1'b1;
            data_in = vec[n];
         end
         if (s_valid && s_ready) begin
            n++;
         end
         @(posedge clk);
         #1;
      end
      s_valid = 1'b0;
      accept_cycle = cycles;
   endtask

   task automatic collect_results(input bit stall, input int accept_cycle);
      int          k;
      logic [31:0] r;
      bit          held_valid;
      data_t       held;
      k = 0;
      held_valid = 1'b0;
      held = '0;
      while (!m_valid) begin
         check_bit("s_ready", 1'b0, s_ready);
         @(posedge clk);
         #1;
         assert (cycles - accept_cycle < max_latency) else begin
            $display("m_valid did not rise within %0d cycles of the last input", max_latency);
            abort_run();
         end
      end
      while (k < `MVM_N_OUT) begin
         r = lcg_next();
         m_ready = stall ? r[18] : 1'b1;
         check_bit("m_valid", 1'b1, m_valid);
         check_bit("s_ready", 1'b0, s_ready);
         if (held_valid) begin
            check_word("data_out while stalled", held, data_out);
         end
         check_word($sformatf("data_out lane %0d", k), exp_out[k], data_out);
         held_valid = !m_ready;
         held = data_out;
         if (m_ready) begin
            k++;
         end
         @(posedge clk);
         #1;
      end
      m_ready = 1'b0;
      check_bit("m_valid", 1'b0, m_valid);
      check_bit("s_ready", 1'b1, s_ready);   // back to loading
   endtask

   task automatic run_frame(input bit in_gaps, input bit out_stall);
      int accept_cycle;
      for (int j = 0; j < `MVM_N_OUT; j++) begin
         exp_out[j] = model_out(j);
      end
      send_vector(in_gaps, accept_cycle);
      collect_results(out_stall, accept_cycle);
   endtask

   task automatic random_vector();
      logic [31:0] r;
      for (int k = 0; k < `MVM_N_IN; k++) begin
         r = lcg_next();
         vec[k] = data_t'(int'(r[22:16]) - 64);   // -64 to 63
      end
   endtask

   // ********************************************************************
   // tests
   // ********************************************************************
   task automatic test_reset();
      int n;
      repeat (2) begin
         @(posedge clk);
         #1;
         check_bit("m_valid", 1'b0, m_valid);
      end
      reset = 1'b0;
      n = 0;
      while (!s_ready) begin
         assert (n < 2) else begin
            $display("s_ready not high within 2 cycles of reset release");
            abort_run();
         end
         @(posedge clk);
         #1;
         check_bit("m_valid", 1'b0, m_valid);
         n++;
      end
   endtask

   task automatic test_zero_vector();
      for (int k = 0; k < `MVM_N_IN; k++) begin
         vec[k] = '0;
      end
      run_frame(1'b0, 1'b0);
   endtask

   task automatic test_one_hot();
      for (int i = 0; i < `MVM_N_IN; i++) begin
         for (int k = 0; k < `MVM_N_IN; k++) begin
            vec[k] = (k == i) ? data_t'(1) : data_t'(0);
         end
         run_frame(1'b0, 1'b0);
      end
   endtask

   task automatic test_random_frames();
      repeat (4) begin
         random_vector();
         run_frame(1'b0, 1'b0);
      end
   endtask

   task automatic test_back_pressure();
      random_vector();
      run_frame(1'b0, 1'b1);
   endtask

   task automatic test_input_gaps();
      random_vector();
      run_frame(1'b1, 1'b0);
   endtask

   initial begin
      reset = 1'b1;
      s_valid = 1'b0;
      data_in = '0;
      m_ready = 1'b0;
      lcg_state = 32'd9590;
      test_reset();
      test_zero_vector();
      test_one_hot();
      test_random_frames();
      test_back_pressure();
      test_input_gaps();
      $display("Test OK");
      $finish;
   end

endmodule

`default_nettype wire

// File: sources.f
+incdir+.
mvm_pkg.sv
layer_rom.sv
input_buffer.sv
mac_lane.sv
mvm_control.sv
mvm_layer.sv
tb_mvm_layer.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f sources.f \
   --top-module tb_mvm_layer -Mdir obj_dir

out=$(./obj_dir/Vtb_mvm_layer) || true
echo "$out"

# fails the script when the pass line is missing
echo "$out" | grep -q "^Test OK$"
